// File: Makefile
# Verilator build and run of the matrix multiply engine testbench

VERILATOR ?= verilator
FILELIST  ?= verilog.f
TOP       ?= tb_mat_mult
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing
PASS_MSG  ?= === PASS ===

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: include/mm_defines.svh
//--------------------------------------------------
// Matrix multiply engine shared widths
// SRAM geometry, dimension fields and fetch latency
//--------------------------------------------------
`ifndef MM_DEFINES_SVH
`define MM_DEFINES_SVH

// SRAM geometry
`define MM_ADDR_W       16
`define MM_DATA_W       32

// Dimension word 0 layout
`define MM_DIM_W        16  // Width of rows or columns field
`define MM_ROWS_LSB     16  // Rows above, columns in the low half

// Cycles from address issue to captured operand
`define MM_FETCH_DEPTH  2

`endif

// File: logic/mat_mult_engine.sv
//--------------------------------------------------
// Matrix multiply engine
// Streams operands from two SRAMs into one MAC
//--------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module mat_mult_engine (
  input  wire                clk,
  input  wire                reset_n,
  input  wire                dut_valid,
  output logic               dut_ready,

  // Input SRAM read port
  output mm_pkg::addr_t      sram_input_read_address,
  input  wire mm_pkg::data_t sram_input_read_data,

  // Weight SRAM read port
  output mm_pkg::addr_t      sram_weight_read_address,
  input  wire mm_pkg::data_t sram_weight_read_data,

  // Result SRAM write port
  output logic               sram_result_write_enable,
  output mm_pkg::addr_t      sram_result_write_address,
  output mm_pkg::data_t      sram_result_write_data
);

  logic dims_load;
  logic run_start;
  logic done_write;

  mm_count_if   count_bus ();
  mm_operand_if operand_bus ();

  mm_control_fsm u_control_fsm (
    .clk        (clk),
    .reset_n    (reset_n),
    .dut_valid  (dut_valid),
    .done_write (done_write),
    .dut_ready  (dut_ready),
    .dims_load  (dims_load),
    .run_start  (run_start),
    .count      (count_bus.fsm)
  );

  // Dimension words arrive straight from the SRAMs
  mm_index_counter u_index_counter (
    .clk         (clk),
    .reset_n     (reset_n),
    .dims_load   (dims_load),
    .input_dims  (sram_input_read_data),
    .weight_dims (sram_weight_read_data),
    .count       (count_bus.counter)
  );

  mm_operand_fetch u_operand_fetch (
    .clk                 (clk),
    .reset_n             (reset_n),
    .run_start           (run_start),
    .input_read_address  (sram_input_read_address),
    .weight_read_address (sram_weight_read_address),
    .input_read_data     (sram_input_read_data),
    .weight_read_data    (sram_weight_read_data),
    .count               (count_bus.fetch),
    .operand             (operand_bus.fetch)
  );

  mm_accumulator u_accumulator (
    .clk           (clk),
    .reset_n       (reset_n),
    .run_start     (run_start),
    .operand       (operand_bus.acc),
    .write_enable  (sram_result_write_enable),
    .write_address (sram_result_write_address),
    .write_data    (sram_result_write_data),
    .done_write    (done_write)
  );

endmodule

`default_nettype wire

// File: logic/mm_accumulator.sv
//--------------------------------------------------
// Accumulator
// Multiply-accumulate and result SRAM write port
//--------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module mm_accumulator (
  input  wire           clk,
  input  wire           reset_n,
  input  wire           run_start,
  mm_operand_if.acc     operand,
  output logic          write_enable,
  output mm_pkg::addr_t write_address,
  output mm_pkg::data_t write_data,
  output logic          done_write
);

  mm_pkg::data_t sum;
  mm_pkg::data_t product;
  mm_pkg::data_t sum_next;

  // Both wrap at 32 bits
  assign product  = operand.a_value * operand.b_value;
  assign sum_next = operand.op_first ? product : sum + product;

  always_ff @(posedge clk) begin
    if (operand.op_valid) begin
      sum <= sum_next;
    end
  end

  // Result address, row-major from 0
  always_ff @(posedge clk) begin
    if (!reset_n || run_start) begin
      write_address <= '0;
    end else if (write_enable) begin
      write_address <= write_address + 1'b1;
    end
  end

  assign write_enable = operand.op_valid && operand.op_last;
  assign write_data   = sum_next;                          // Written in the op_last cycle
  assign done_write   = write_enable && operand.op_final;  // Ends the run

endmodule

`default_nettype wire

// File: logic/mm_control_fsm.sv
//--------------------------------------------------
// Control FSM
// Sequences dimension load, streaming and drain
//--------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module mm_control_fsm (
  input  wire  clk,
  input  wire  reset_n,
  input  wire  dut_valid,
  input  wire  done_write,
  output logic dut_ready,
  output logic dims_load,
  output logic run_start,
  mm_count_if.fsm count
);

  mm_pkg::state_e state;
  mm_pkg::state_e next_state;
  logic           last_issue;

  // Final pair of the matrix goes out this cycle
  assign last_issue = count.k_last && count.col_last && count.row_last;

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      state     <= mm_pkg::IDLE;
      dut_ready <= 1'b0;
    end else begin
      state     <= next_state;
      dut_ready <= (next_state == mm_pkg::IDLE);  // Ready only while idle
    end
  end

  always_comb begin
    next_state = state;
    case (state)
      mm_pkg::IDLE: begin
        if (dut_valid && dut_ready) begin
          next_state = mm_pkg::READ_DIMS;
        end
      end
      mm_pkg::READ_DIMS: next_state = mm_pkg::LOAD_DIMS;
      mm_pkg::LOAD_DIMS: next_state = mm_pkg::STREAM;
      mm_pkg::STREAM: begin
        if (last_issue) begin
          next_state = mm_pkg::DRAIN;
        end
      end
      mm_pkg::DRAIN: begin
        if (done_write) begin
          next_state = mm_pkg::IDLE;
        end
      end
      default: next_state = mm_pkg::IDLE;
    endcase
  end

  assign run_start  = (state == mm_pkg::READ_DIMS);
  assign dims_load  = (state == mm_pkg::LOAD_DIMS);
  assign count.step = (state == mm_pkg::STREAM);

endmodule

`default_nettype wire

// File: logic/mm_count_if.sv
//--------------------------------------------------
// Iteration event bus
// Counter flags and FSM step to control and fetch
//--------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

interface mm_count_if;

  logic step;      // Issue one read pair this cycle
  logic k_first;   // First inner element of a dot product
  logic k_last;    // Last inner element of a dot product
  logic col_last;  // Last weight column of the row
  logic row_last;  // Last input row

  modport counter (
    input  step,
    output k_first, k_last, col_last, row_last
  );

  modport fsm (
    output step,
    input  k_last, col_last, row_last
  );

  modport fetch (
    input step, k_first, k_last, col_last, row_last
  );

endinterface

`default_nettype wire

// File: logic/mm_index_counter.sv
//--------------------------------------------------
// Index counter
// Dimension registers and inner, column, row iterators
//--------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

`include "mm_defines.svh"

module mm_index_counter (
  input  wire                clk,
  input  wire                reset_n,
  input  wire                dims_load,
  input  wire mm_pkg::data_t input_dims,
  input  wire mm_pkg::data_t weight_dims,
  mm_count_if.counter        count
);

  mm_pkg::dim_t rows;      // Input rows
  mm_pkg::dim_t inner;     // Input columns, dot product length
  mm_pkg::dim_t cols;      // Weight columns
  mm_pkg::dim_t k_iter;
  mm_pkg::dim_t col_iter;
  mm_pkg::dim_t row_iter;

  // --------------------------------------------------
  // Dimension capture
  // --------------------------------------------------
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      rows  <= '0;
      inner <= '0;
      cols  <= '0;
    end else if (dims_load) begin
      rows  <= input_dims[`MM_ROWS_LSB +: `MM_DIM_W];
      inner <= input_dims[`MM_DIM_W-1:0];
      cols  <= weight_dims[`MM_DIM_W-1:0];  // Weight rows taken as equal to inner
    end
  end

  // --------------------------------------------------
  // Iterators, inner wraps into column into row
  // --------------------------------------------------
  always_ff @(posedge clk) begin
    if (!reset_n || dims_load) begin
      k_iter   <= '0;
      col_iter <= '0;
      row_iter <= '0;
    end else if (count.step) begin
      if (!count.k_last) begin
        k_iter <= k_iter + 1'b1;
      end else begin
        k_iter <= '0;
        if (!count.col_last) begin
          col_iter <= col_iter + 1'b1;
        end else begin
          col_iter <= '0;
          row_iter <= count.row_last ? '0 : row_iter + 1'b1;
        end
      end
    end
  end

  // Flags for the pair issued this cycle
  assign count.k_first  = (k_iter == '0);
  assign count.k_last   = (k_iter == inner - 1'b1);
  assign count.col_last = (col_iter == cols - 1'b1);
  assign count.row_last = (row_iter == rows - 1'b1);

endmodule

`default_nettype wire

// File: logic/mm_operand_fetch.sv
//--------------------------------------------------
// Operand fetch
// Read addresses, SRAM data capture and tag delay
//--------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

`include "mm_defines.svh"

module mm_operand_fetch (
  input  wire                 clk,
  input  wire                 reset_n,
  input  wire                 run_start,
  output mm_pkg::addr_t       input_read_address,
  output mm_pkg::addr_t       weight_read_address,
  input  wire mm_pkg::data_t  input_read_data,
  input  wire mm_pkg::data_t  weight_read_data,
  mm_count_if.fetch           count,
  mm_operand_if.fetch         operand
);

  mm_pkg::addr_t in_addr;   // Input element of the current issue
  mm_pkg::addr_t row_base;  // First element of the current input row
  mm_pkg::addr_t wt_addr;   // Weight element, columns are contiguous

  logic [`MM_FETCH_DEPTH-1:0] valid_pipe;
  logic [`MM_FETCH_DEPTH-1:0] first_pipe;
  logic [`MM_FETCH_DEPTH-1:0] last_pipe;
  logic [`MM_FETCH_DEPTH-1:0] final_pipe;
  logic                       final_issue;

  assign final_issue = count.k_last && count.col_last && count.row_last;

  // --------------------------------------------------
  // Address generation, additions only
  // --------------------------------------------------
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      in_addr  <= '0;
      row_base <= '0;
      wt_addr  <= '0;
    end else if (run_start) begin
      in_addr  <= mm_pkg::addr_t'(1);  // Elements start after word 0
      row_base <= mm_pkg::addr_t'(1);
      wt_addr  <= mm_pkg::addr_t'(1);
    end else if (count.step) begin
      if (!count.k_last) begin
        in_addr <= in_addr + 1'b1;
        wt_addr <= wt_addr + 1'b1;
      end else if (!count.col_last) begin
        in_addr <= row_base;         // Same row, next column
        wt_addr <= wt_addr + 1'b1;
      end else begin
        in_addr  <= in_addr + 1'b1;  // Next row follows directly
        row_base <= in_addr + 1'b1;
        wt_addr  <= mm_pkg::addr_t'(1);
      end
    end
  end

  // Word 0 during READ_DIMS
  assign input_read_address  = run_start ? '0 : in_addr;
  assign weight_read_address = run_start ? '0 : wt_addr;

  // --------------------------------------------------
  // Tag delay and data capture
  // --------------------------------------------------
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      valid_pipe <= '0;
    end else begin
      valid_pipe <= {valid_pipe[`MM_FETCH_DEPTH-2:0], count.step};
    end
  end

  always_ff @(posedge clk) begin
    first_pipe <= {first_pipe[`MM_FETCH_DEPTH-2:0], count.k_first};
    last_pipe  <= {last_pipe[`MM_FETCH_DEPTH-2:0], count.k_last};
    final_pipe <= {final_pipe[`MM_FETCH_DEPTH-2:0], final_issue};
    if (valid_pipe[0]) begin  // SRAM data of last cycle's issue
      operand.a_value <= input_read_data;
      operand.b_value <= weight_read_data;
    end
  end

  assign operand.op_valid = valid_pipe[`MM_FETCH_DEPTH-1];
  assign operand.op_first = first_pipe[`MM_FETCH_DEPTH-1];
  assign operand.op_last  = last_pipe[`MM_FETCH_DEPTH-1];
  assign operand.op_final = final_pipe[`MM_FETCH_DEPTH-1];

endmodule

`default_nettype wire

// File: logic/mm_operand_if.sv
//--------------------------------------------------
// Operand stream from fetch to accumulator
// Strobe stream of element pairs, no back-pressure
//--------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

interface mm_operand_if;

  logic          op_valid;
  logic          op_first;  // Restart the sum with this product
  logic          op_last;   // Sum is complete after this product
  logic          op_final;  // Last product of the whole matrix
  mm_pkg::data_t a_value;   // Input matrix element
  mm_pkg::data_t b_value;   // Weight matrix element

  modport fetch (
    output op_valid, op_first, op_last, op_final,
    output a_value, b_value
  );

  modport acc (
    input op_valid, op_first, op_last, op_final,
    input a_value, b_value
  );

endinterface

`default_nettype wire

// File: logic/mm_pkg.sv
//--------------------------------------------------
// Matrix multiply engine types
// Address, data, dimension and FSM state types
//--------------------------------------------------
`default_nettype none

`include "mm_defines.svh"

package mm_pkg;

  typedef logic [`MM_ADDR_W-1:0] addr_t;
  typedef logic [`MM_DATA_W-1:0] data_t;  // Also the wrapped accumulator
  typedef logic [`MM_DIM_W-1:0]  dim_t;

  // Control FSM states
  typedef enum logic [2:0] {
    IDLE      = 3'd0,
    READ_DIMS = 3'd1,  // Word 0 address on both SRAMs
    LOAD_DIMS = 3'd2,  // Dimension words return
    STREAM    = 3'd3,  // One read pair per cycle
    DRAIN     = 3'd4   // Wait for the last write
  } state_e;

endpackage

`default_nettype wire

// File: test/tb_mat_mult.sv
//--------------------------------------------------
// Matrix multiply engine testbench
// SRAM models, case table and golden product check
//--------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module tb_mat_mult;

  localparam int NUM_CASES = 6;
  localparam int MAX_DIM   = 8;
  localparam int TIMEOUT   = 2000;  // Cycles per run

  // Case table, elements are random words under a mask
  string       case_name  [NUM_CASES] = '{"one_by_one", "rect_3x4_4x2", "rect_2x5_5x3",
                                          "square_4", "col_times_row", "large_values"};
  int          case_rows  [NUM_CASES] = '{1, 3, 2, 4, 5, 3};
  int          case_inner [NUM_CASES] = '{1, 4, 5, 4, 1, 3};
  int          case_cols  [NUM_CASES] = '{1, 2, 3, 4, 4, 3};
  logic [31:0] case_mask  [NUM_CASES] = '{32'hff, 32'h3ff, 32'h3ff, 32'hffff, 32'hf,
                                          32'hffff_ffff};

  logic          clk;
  logic          reset_n;
  logic          dut_valid;
  logic          dut_ready;
  mm_pkg::addr_t in_addr;
  mm_pkg::data_t input_rdata = '0;
  mm_pkg::addr_t wt_addr;
  mm_pkg::data_t weight_rdata = '0;
  logic          write_en;
  mm_pkg::addr_t wr_addr;
  mm_pkg::data_t wr_data;

  logic [31:0] input_mem  [0:65535];
  logic [31:0] weight_mem [0:65535];
  logic [31:0] result_mem [0:65535];
  logic [31:0] a_mat [0:MAX_DIM-1][0:MAX_DIM-1];
  logic [31:0] b_mat [0:MAX_DIM-1][0:MAX_DIM-1];
  string       cur_name;
  int          expected_writes;  // Zero outside a run
  int          write_count;

  mat_mult_engine u_dut (
    .clk                       (clk),
    .reset_n                   (reset_n),
    .dut_valid                 (dut_valid),
    .dut_ready                 (dut_ready),
    .sram_input_read_address   (in_addr),
    .sram_input_read_data      (input_rdata),
    .sram_weight_read_address  (wt_addr),
    .sram_weight_read_data     (weight_rdata),
    .sram_result_write_enable  (write_en),
    .sram_result_write_address (wr_addr),
    .sram_result_write_data    (wr_data)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // --------------------------------------------------
  // SRAM models, one-cycle reads
  // --------------------------------------------------
  always @(posedge clk) begin
    input_rdata  <= input_mem[in_addr];
    weight_rdata <= weight_mem[wt_addr];
  end

  // Result writes must come in order from address 0
  always @(posedge clk) begin
    if (reset_n && write_en) begin
      assert (write_count < expected_writes) else
        abort_run($sformatf("Unexpected result write to address %0d in %s", wr_addr, cur_name));
      assert (wr_addr == mm_pkg::addr_t'(write_count)) else
        value_error(cur_name, "write address", 32'(write_count), 32'(wr_addr));
      result_mem[wr_addr] = wr_data;
      write_count = write_count + 1;
    end
  end

  // --------------------------------------------------
  // Error reporting
  // --------------------------------------------------
  task automatic value_error(input string test, input string what,
                             input logic [31:0] expected, input logic [31:0] actual);
    $display("Error in %s: %s expected 0x%08h actual 0x%08h", test, what, expected, actual);
    $display("=== FAIL ===");
    $fatal(1, "mismatch");
  endtask

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("=== FAIL ===");
    $fatal(1, "stopped");
  endtask

  // Operand layout: word 0 dims, input row-major, weight column by column
  task automatic fill_case(input int rows, input int inner, input int cols,
                           input logic [31:0] mask);
    input_mem[0]  = {16'(rows), 16'(inner)};
    weight_mem[0] = {16'(inner), 16'(cols)};
    for (int r = 0; r < rows; r++) begin
      for (int k = 0; k < inner; k++) begin
        a_mat[r][k] = $urandom & mask;
        input_mem[1 + r * inner + k] = a_mat[r][k];
      end
    end
    for (int c = 0; c < cols; c++) begin
      for (int k = 0; k < inner; k++) begin
        b_mat[k][c] = $urandom & mask;
        weight_mem[1 + c * inner + k] = b_mat[k][c];
      end
    end
    for (int i = 0; i < MAX_DIM * MAX_DIM; i++) begin
      result_mem[i] = 32'hdead_0000 | 32'(i);  // Marks unwritten words
    end
  endtask

  // Golden product, wraps at 32 bits
  task automatic check_results(input int rows, input int inner, input int cols);
    logic [31:0] expected;
    for (int r = 0; r < rows; r++) begin
      for (int c = 0; c < cols; c++) begin
        expected = '0;
        for (int k = 0; k < inner; k++) begin
          expected = expected + a_mat[r][k] * b_mat[k][c];
        end
        assert (result_mem[r * cols + c] === expected) else
          value_error(cur_name, $sformatf("result[%0d][%0d]", r, c), expected,
                      result_mem[r * cols + c]);
      end
    end
  endtask

  task automatic run_case(input int idx);
    int cycles;
    cur_name = case_name[idx];
    fill_case(case_rows[idx], case_inner[idx], case_cols[idx], case_mask[idx]);
    write_count     = 0;
    expected_writes = case_rows[idx] * case_cols[idx];
    dut_valid = 1'b1;
    @(negedge clk);
    dut_valid = 1'b0;
    assert (dut_ready === 1'b0) else
      abort_run($sformatf("dut_ready stayed high after dut_valid in %s", cur_name));
    cycles = 0;
    while (dut_ready !== 1'b1 && cycles < TIMEOUT) begin
      @(negedge clk);
      cycles++;
    end
    assert (dut_ready === 1'b1) else
      abort_run($sformatf("Timed out waiting for dut_ready in %s", cur_name));
    assert (write_count == expected_writes) else
      value_error(cur_name, "write count", 32'(expected_writes), 32'(write_count));
    expected_writes = 0;  // Any write while idle is an error
    check_results(case_rows[idx], case_inner[idx], case_cols[idx]);
  endtask

  // --------------------------------------------------
  // Main sequence
  // --------------------------------------------------
  initial begin
    void'($urandom(32'h44c8));
    reset_n         = 1'b0;
    dut_valid       = 1'b0;
    expected_writes = 0;
    write_count     = 0;
    cur_name        = "reset";
    repeat (10) @(negedge clk);
    reset_n = 1'b1;
    @(negedge clk);
    assert (dut_ready === 1'b1) else abort_run("dut_ready is not high after reset");
    assert (write_en === 1'b0) else abort_run("Result write enable is high after reset");
    for (int i = 0; i < NUM_CASES; i++) begin
      run_case(i);  // Back to back, no reset between runs
    end
    $display("=== PASS ===");
    $finish;
  end

endmodule

`default_nettype wire

// File: verilog.f
+incdir+include
logic/mm_pkg.sv
logic/mm_count_if.sv
logic/mm_operand_if.sv
logic/mm_control_fsm.sv
logic/mm_index_counter.sv
logic/mm_operand_fetch.sv
logic/mm_accumulator.sv
logic/mat_mult_engine.sv
test/tb_mat_mult.sv
